// File: rom_check_defines.svh
// Image geometry and digest seed for the ROM checker, included by packages and RTL
`ifndef ROM_CHECK_DEFINES_SVH
`define ROM_CHECK_DEFINES_SVH

// Data words folded into the digest
`define ROM_DATA_WORDS 6

// 32-bit words in a digest
`define ROM_DIGEST_WORDS 2

// Whole image, data followed by expected digest
`define ROM_TOTAL_WORDS (`ROM_DATA_WORDS + `ROM_DIGEST_WORDS)

// Start value of every digest lane
`define ROM_DIGEST_SEED 32'h6A09_E667

`endif

// File: rom_stream_pkg.sv
// ROM word stream and digest types, imported by the receiver, engine and top level
`include "rom_check_defines.svh"

package rom_stream_pkg;

  // Word address inside one image
  typedef logic [2:0] rom_addr_t;

  // One word on the input link
  typedef struct packed {
    rom_addr_t   addr;
    logic [31:0] data;
  } rom_word_t;

  // Digest as an array of 32-bit words
  // Word 0 sits in the LSBs
  typedef logic [`ROM_DIGEST_WORDS-1:0][31:0] rom_digest_t;

endpackage

// File: rom_status_pkg.sv
// Check status types, used by the comparator, the result sender and the top level
package rom_status_pkg;

  // Multi-bit boolean
  // Only the two values below are legal
  typedef logic [3:0] mubi4_t;

  parameter mubi4_t MUBI4_TRUE  = 4'h6;
  parameter mubi4_t MUBI4_FALSE = 4'h9;

  // Verdict offered to the downstream consumer
  typedef struct packed {
    mubi4_t good;
    logic   alert;
  } rom_result_t;

  // Single-bit to multi-bit boolean
  function automatic mubi4_t mubi4_from_bool(logic b);
    return b ? MUBI4_TRUE : MUBI4_FALSE;
  endfunction

endpackage

// File: rom_word_receiver.sv
// Input side of the ROM checker: four-phase word receiver with order check and start pulse
`include "rom_check_defines.svh"

module rom_word_receiver (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rom_req_i,
  input  rom_stream_pkg::rom_word_t   rom_word_i,
  output logic                        rom_ack_o,
  output logic                        word_valid_o,
  output logic [31:0]                 word_data_o,
  output rom_stream_pkg::rom_digest_t exp_digest_o,
  output logic                        seq_error_o,
  output logic                        start_o
);
  import rom_stream_pkg::*;

  localparam int DigIdxW = ($clog2(`ROM_DIGEST_WORDS) > 0) ? $clog2(`ROM_DIGEST_WORDS) : 1;
  localparam rom_addr_t FirstDigAddr = rom_addr_t'(`ROM_DATA_WORDS);
  localparam rom_addr_t LastAddr     = rom_addr_t'(`ROM_TOTAL_WORDS - 1);

  logic               ack_q;
  logic               capture;
  logic               ack_release;
  rom_addr_t          cnt_q;
  logic               last_seen_q;
  logic               seq_error_q;
  logic               start_q;
  rom_digest_t        exp_digest_q;
  rom_addr_t          dig_off;
  logic [DigIdxW-1:0] dig_idx;

  // New request while ack is low, word taken on this edge
  assign capture     = rom_req_i && !ack_q;
  // Source has dropped req, finish the handshake
  assign ack_release = ack_q && !rom_req_i;

  // Position inside the expected digest
  assign dig_off = cnt_q - FirstDigAddr;
  assign dig_idx = dig_off[DigIdxW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      cnt_q       <= '0;
      last_seen_q <= 1'b0;
      seq_error_q <= 1'b0;
      start_q     <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (capture) begin
        ack_q <= 1'b1;
        cnt_q <= (cnt_q == LastAddr) ? '0 : cnt_q + rom_addr_t'(1);
        // Last word of the image, start once its handshake is over
        if (cnt_q == LastAddr) begin
          last_seen_q <= 1'b1;
        end
        // Out-of-order word is still consumed, error is sticky
        if (rom_word_i.addr != cnt_q) begin
          seq_error_q <= 1'b1;
        end
      end
      if (ack_release) begin
        ack_q <= 1'b0;
        if (last_seen_q) begin
          start_q     <= 1'b1;
          last_seen_q <= 1'b0;
        end
      end
    end
  end

  // Expected digest words, routed by position in the stream
  always_ff @(posedge clk_i) begin
    if (capture && (cnt_q >= FirstDigAddr)) begin
      exp_digest_q[dig_idx] <= rom_word_i.data;
    end
  end

  // Data words go straight to the engine in the capture cycle
  assign word_valid_o = capture && (cnt_q < FirstDigAddr);
  assign word_data_o  = rom_word_i.data;

  assign rom_ack_o    = ack_q;
  assign exp_digest_o = exp_digest_q;
  assign seq_error_o  = seq_error_q;
  assign start_o      = start_q;

endmodule

// File: rom_digest_engine.sv
// Digest engine of the ROM checker: rotate-xor fold of data words into interleaved lanes
`include "rom_check_defines.svh"

module rom_digest_engine (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        word_valid_i,
  input  logic [31:0]                 word_data_i,
  output rom_stream_pkg::rom_digest_t digest_o
);
  import rom_stream_pkg::*;

  localparam int LaneW = ($clog2(`ROM_DIGEST_WORDS) > 0) ? $clog2(`ROM_DIGEST_WORDS) : 1;
  localparam logic [LaneW-1:0] LastLane = LaneW'(`ROM_DIGEST_WORDS - 1);

  rom_digest_t      digest_q;
  logic [LaneW-1:0] lane_q;
  logic [31:0]      lane_word;
  logic [31:0]      folded;

  // Current lane value
  assign lane_word = digest_q[lane_q];

  // Rotate left by 5, then mix in the new word
  assign folded = {lane_word[26:0], lane_word[31:27]} ^ word_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= {`ROM_DIGEST_WORDS{`ROM_DIGEST_SEED}};
      lane_q   <= '0;
    end else if (word_valid_i) begin
      digest_q[lane_q] <= folded;
      // Word k lands in lane k mod ROM_DIGEST_WORDS
      lane_q <= (lane_q == LastLane) ? '0 : lane_q + 1'b1;
    end
  end

  assign digest_o = digest_q;

endmodule

// File: rom_check_compare.sv
// Digest comparator of the ROM checker: sparse FSM walking both digests, with consistency alert
`include "rom_check_defines.svh"

module rom_check_compare (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  rom_stream_pkg::rom_digest_t digest_i,
  input  rom_stream_pkg::rom_digest_t exp_digest_i,
  output logic                        done_o,
  output rom_status_pkg::mubi4_t      good_o,
  output logic                        alert_o
);
  import rom_status_pkg::*;

  localparam int AW = ($clog2(`ROM_DIGEST_WORDS) > 0) ? $clog2(`ROM_DIGEST_WORDS) : 1;
  localparam logic [AW-1:0] LastAddr = AW'(`ROM_DIGEST_WORDS - 1);

  // Sparse encoding, pairwise Hamming distance of at least 3
  typedef enum logic [4:0] {
    Waiting  = 5'b00100,
    Checking = 5'b10010,
    Done     = 5'b11001
  } state_e;

  state_e        state_q;
  state_e        state_d;
  logic [AW-1:0] addr_q;
  logic          matches_q;
  logic          matches_d;
  logic          word_eq;
  mubi4_t        good_q;
  logic [31:0]   digest_word;
  logic [31:0]   exp_word;
  logic          fsm_alert;
  logic          start_alert;
  logic          wait_addr_alert;
  logic          done_addr_alert;

  // Waiting until start, one word per cycle in Checking, then stuck in Done
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    unique case (state_q)
      Waiting: begin
        if (start_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (addr_q == LastAddr) begin
          state_d = Done;
        end
      end
      Done: begin
        // Terminal
      end
      default: fsm_alert = 1'b1;
    endcase
  end

  // Word under comparison
  assign digest_word = digest_i[addr_q];
  assign exp_word    = exp_digest_i[addr_q];
  assign word_eq     = (digest_word == exp_word);

  // Mismatch is sticky, only Checking may change it
  assign matches_d = (state_q == Checking) ? (matches_q && word_eq) : matches_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Waiting;
      addr_q    <= '0;
      matches_q <= 1'b1;
      good_q    <= MUBI4_FALSE;
    end else begin
      state_q <= state_d;
      // Stops at the last word
      if ((state_q == Checking) && (addr_q != LastAddr)) begin
        addr_q <= addr_q + 1'b1;
      end
      matches_q <= matches_d;
      // Valid alongside matches, so it is final when done rises
      good_q    <= mubi4_from_bool(matches_d);
    end
  end

  // Start is only legal in Waiting
  assign start_alert     = start_i && (state_q != Waiting);
  // Counter must agree with the state
  assign wait_addr_alert = (state_q == Waiting) && (addr_q != '0);
  assign done_addr_alert = (state_q == Done) && (addr_q != LastAddr);

  assign done_o  = (state_q == Done);
  assign good_o  = good_q;
  assign alert_o = fsm_alert | start_alert | wait_addr_alert | done_addr_alert;

endmodule

// File: rom_result_sender.sv
// Output side of the ROM checker: latches the verdict and offers it once over four-phase req/ack
module rom_result_sender (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        done_i,
  input  rom_status_pkg::mubi4_t      good_i,
  input  logic                        cmp_alert_i,
  input  logic                        seq_error_i,
  output logic                        res_req_o,
  input  logic                        res_ack_i,
  output rom_status_pkg::rom_result_t res_o
);
  import rom_status_pkg::*;

  typedef enum logic [1:0] {
    Idle  = 2'b00,
    Offer = 2'b01,
    Sent  = 2'b10
  } state_e;

  state_e      state_q;
  rom_result_t res_q;
  logic        alert_in;

  // Both alert sources merge into one flag
  assign alert_in = cmp_alert_i | seq_error_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      res_q.good  <= MUBI4_FALSE;
      res_q.alert <= 1'b0;
    end else begin
      unique case (state_q)
        Idle: begin
          // First rise of done, req goes high on the same edge
          if (done_i) begin
            res_q.good  <= good_i;
            res_q.alert <= alert_in;
            state_q     <= Offer;
          end
        end
        Offer: begin
          // Late alerts still count until the sink answers
          res_q.alert <= res_q.alert | alert_in;
          if (res_ack_i) begin
            state_q <= Sent;
          end
        end
        Sent: begin
          // One verdict per reset
        end
        default: state_q <= Idle;
      endcase
    end
  end

  assign res_req_o = (state_q == Offer);
  assign res_o     = res_q;

endmodule

// File: rom_check_top.sv
// Top level of the ROM integrity checker, joining receiver, digest engine, comparator and sender
module rom_check_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rom_req_i,
  input  rom_stream_pkg::rom_word_t   rom_word_i,
  output logic                        rom_ack_o,
  output logic                        res_req_o,
  input  logic                        res_ack_i,
  output rom_status_pkg::rom_result_t res_o
);
  import rom_stream_pkg::*;
  import rom_status_pkg::*;

  logic        word_valid;
  logic [31:0] word_data;
  rom_digest_t exp_digest;
  rom_digest_t digest;
  logic        seq_error;
  logic        start;
  logic        done;
  mubi4_t      good;
  logic        cmp_alert;

  // Input handshake and word routing
  rom_word_receiver u_receiver (
    .clk_i,
    .rst_ni,
    .rom_req_i,
    .rom_word_i,
    .rom_ack_o,
    .word_valid_o (word_valid),
    .word_data_o  (word_data),
    .exp_digest_o (exp_digest),
    .seq_error_o  (seq_error),
    .start_o      (start)
  );

  rom_digest_engine u_engine (
    .clk_i,
    .rst_ni,
    .word_valid_i (word_valid),
    .word_data_i  (word_data),
    .digest_o     (digest)
  );

  rom_check_compare u_compare (
    .clk_i,
    .rst_ni,
    .start_i      (start),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .done_o       (done),
    .good_o       (good),
    .alert_o      (cmp_alert)
  );

  // Verdict towards the downstream consumer
  rom_result_sender u_sender (
    .clk_i,
    .rst_ni,
    .done_i      (done),
    .good_i      (good),
    .cmp_alert_i (cmp_alert),
    .seq_error_i (seq_error),
    .res_req_o,
    .res_ack_i,
    .res_o
  );

endmodule

// File: tb_rom_check.sv
// Directed testbench that drives rom_check_top as the top of the simulation
`include "rom_check_defines.svh"

module tb_rom_check;
  timeunit 1ns;
  timeprecision 100ps;

  import rom_stream_pkg::*;
  import rom_status_pkg::*;

  // Six tests of about 80 cycles each plus margin
  localparam int timeout_cycles = 1000;
  // Longest wait for one handshake phase
  localparam int phase_limit = 100;

  logic        clk_i;
  logic        rst_ni;
  logic        rom_req_i;
  rom_word_t   rom_word_i;
  logic        rom_ack_o;
  logic        res_req_o;
  logic        res_ack_i;
  rom_result_t res_o;

  logic [31:0] lcg_state;
  logic [31:0] image [`ROM_TOTAL_WORDS];
  int          cycle_cnt;
  int          tests_run;
  int          checks_run;
  int          error_cnt;
  int          words_acked;

  rom_check_top dut_i (
    .clk_i,
    .rst_ni,
    .rom_req_i,
    .rom_word_i,
    .rom_ack_o,
    .res_req_o,
    .res_ack_i,
    .res_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference fold with every lane starting at the seed
  function automatic rom_digest_t model_digest(input logic [31:0] words [`ROM_TOTAL_WORDS]);
    rom_digest_t lanes;
    logic [31:0] lane;
    lanes = {`ROM_DIGEST_WORDS{`ROM_DIGEST_SEED}};
    for (int k = 0; k < `ROM_DATA_WORDS; k++) begin
      // With two lanes k mod 2 is bit 0 of k
      lane = lanes[k[0]];
      lanes[k[0]] = {lane[26:0], lane[31:27]} ^ words[rom_addr_t'(k)];
    end
    return lanes;
  endfunction

  // Inputs change and outputs are read 10 ns after the edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks_run++;
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic check_verdict(input rom_result_t res, input mubi4_t good, input logic alert);
    check_value("res_o.good", 64'(res.good), 64'(good));
    check_value("res_o.alert", 64'(res.alert), 64'(alert));
  endtask

  task automatic reset_dut();
    rst_ni     = 1'b0;
    rom_req_i  = 1'b0;
    rom_word_i = '0;
    res_ack_i  = 1'b0;
    repeat (16) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    next_cycle();
  endtask

  // Random data words followed by the modelled digest in words 6 and 7
  task automatic fill_image();
    rom_addr_t   idx;
    rom_digest_t dig;
    for (int i = 0; i < `ROM_DATA_WORDS; i++) begin
      idx        = rom_addr_t'(i);
      image[idx] = lcg_next();
    end
    dig = model_digest(image);
    image[rom_addr_t'(`ROM_DATA_WORDS)]     = dig[0];
    image[rom_addr_t'(`ROM_DATA_WORDS + 1)] = dig[1];
  endtask

  // Four-phase source for one word
  task automatic send_word(input rom_addr_t addr, input logic [31:0] data);
    int   waited;
    logic acked;
    rom_word_i.addr = addr;
    rom_word_i.data = data;
    rom_req_i       = 1'b1;
    waited          = 0;
    next_cycle();
    while (!rom_ack_o && waited < phase_limit) begin
      next_cycle();
      waited++;
    end
    acked = rom_ack_o;
    if (!acked) begin
      $display("rom_ack_o never rose for the word at address %0d", addr);
      error_cnt++;
    end
    rom_req_i = 1'b0;
    waited    = 0;
    next_cycle();
    while (rom_ack_o && waited < phase_limit) begin
      next_cycle();
      waited++;
    end
    if (rom_ack_o) begin
      $display("rom_ack_o never fell for the word at address %0d", addr);
      error_cnt++;
    end else if (acked) begin
      words_acked++;
    end
  endtask

  // Whole image in order where two positions may trade places
  task automatic send_image(input int max_gap, input int swap_a, input int swap_b);
    int        src;
    int        gap;
    rom_addr_t idx;
    for (int p = 0; p < `ROM_TOTAL_WORDS; p++) begin
      src = p;
      if (p == swap_a) begin
        src = swap_b;
      end else if (p == swap_b) begin
        src = swap_a;
      end
      idx = rom_addr_t'(src);
      send_word(idx, image[idx]);
      gap = (max_gap > 0) ? int'(lcg_next() % 32'(max_gap + 1)) : 0;
      repeat (gap) next_cycle();
    end
  endtask

  // Four-phase sink that checks the verdict holds while ack is delayed
  task automatic get_result(input int ack_delay, output rom_result_t res);
    int waited;
    waited = 0;
    res    = '0;
    while (!res_req_o && waited < phase_limit) begin
      next_cycle();
      waited++;
    end
    if (!res_req_o) begin
      $display("res_req_o never rose after the image was sent");
      error_cnt++;
    end else begin
      res = res_o;
      repeat (ack_delay) begin
        next_cycle();
        check_value("res_req_o", 64'(res_req_o), 64'(1'b1));
        check_value("res_o", 64'(res_o), 64'(res));
      end
      res_ack_i = 1'b1;
      waited    = 0;
      next_cycle();
      while (res_req_o && waited < phase_limit) begin
        next_cycle();
        waited++;
      end
      if (res_req_o) begin
        $display("res_req_o stayed high after res_ack_i rose");
        error_cnt++;
      end
      res_ack_i = 1'b0;
      next_cycle();
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (error_cnt == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, error_cnt - errors_before);
    end
  endtask

  task automatic test_good_image();
    int          errors_before;
    rom_result_t res;
    errors_before = error_cnt;
    reset_dut();
    // Idle outputs after reset
    check_value("rom_ack_o", 64'(rom_ack_o), 64'(1'b0));
    check_value("res_req_o", 64'(res_req_o), 64'(1'b0));
    check_verdict(res_o, MUBI4_FALSE, 1'b0);
    fill_image();
    send_image(0, 0, 0);
    get_result(0, res);
    check_verdict(res, MUBI4_TRUE, 1'b0);
    end_test("good image", errors_before);
  endtask

  task automatic test_flipped_data();
    int          errors_before;
    rom_result_t res;
    errors_before = error_cnt;
    reset_dut();
    fill_image();
    // Digest is already modelled so the fold no longer matches
    image[rom_addr_t'(2)] = image[rom_addr_t'(2)] ^ 32'h0000_0100;
    send_image(0, 0, 0);
    get_result(0, res);
    check_verdict(res, MUBI4_FALSE, 1'b0);
    end_test("flipped data word", errors_before);
  endtask

  task automatic test_bad_upper_digest();
    int          errors_before;
    rom_result_t res;
    errors_before = error_cnt;
    reset_dut();
    fill_image();
    // Lower digest word intact
    image[rom_addr_t'(7)] = image[rom_addr_t'(7)] ^ 32'h8000_0000;
    send_image(0, 0, 0);
    get_result(0, res);
    check_verdict(res, MUBI4_FALSE, 1'b0);
    end_test("bad upper digest word", errors_before);
  endtask

  task automatic test_swapped_addr();
    int          errors_before;
    rom_result_t res;
    errors_before = error_cnt;
    reset_dut();
    fill_image();
    send_image(0, 3, 4);
    get_result(0, res);
    check_value("res_o.alert", 64'(res.alert), 64'(1'b1));
    end_test("swapped addresses", errors_before);
  endtask

  task automatic test_back_pressure();
    int          errors_before;
    int          ack_delay;
    rom_result_t res;
    errors_before = error_cnt;
    reset_dut();
    fill_image();
    send_image(3, 0, 0);
    ack_delay = int'(lcg_next() % 32'd21);
    get_result(ack_delay, res);
    check_verdict(res, MUBI4_TRUE, 1'b0);
    end_test("slow source and sink", errors_before);
  endtask

  task automatic test_second_image();
    int          errors_before;
    int          rises;
    rom_result_t res;
    errors_before = error_cnt;
    reset_dut();
    fill_image();
    send_image(0, 0, 0);
    get_result(0, res);
    check_verdict(res, MUBI4_TRUE, 1'b0);
    // Without reset the new start lands while the comparator sits in Done
    words_acked = 0;
    fill_image();
    send_image(0, 0, 0);
    check_value("rom_ack_o handshakes", 64'(words_acked), 64'(`ROM_TOTAL_WORDS));
    rises = 0;
    repeat (50) begin
      next_cycle();
      if (res_req_o) begin
        rises++;
      end
    end
    check_value("res_req_o high cycles", 64'(rises), 64'(0));
    end_test("second image without reset", errors_before);
  endtask

  initial begin
    rst_ni      = 1'b0;
    rom_req_i   = 1'b0;
    rom_word_i  = '0;
    res_ack_i   = 1'b0;
    lcg_state   = 32'd22;
    tests_run   = 0;
    checks_run  = 0;
    error_cnt   = 0;
    words_acked = 0;
    test_good_image();
    test_flipped_data();
    test_bad_upper_digest();
    test_swapped_addr();
    test_back_pressure();
    test_second_image();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks_run, error_cnt);
    if (error_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: rom_check.f
+incdir+.
rom_stream_pkg.sv
rom_status_pkg.sv
rom_word_receiver.sv
rom_digest_engine.sv
rom_check_compare.sv
rom_result_sender.sv
rom_check_top.sv
tb_rom_check.sv

// File: run_sim.sh
#!/bin/sh
# Build the ROM checker testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_rom_check -f rom_check.f -Mdir obj_dir -o sim_rom_check
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_rom_check > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
  echo "simulation reported failure"
  exit 1
fi
exit 0
